//--- egr_port_array_adapt.f
common/egr_pkg.sv
egr_port_gate/egr_port_gate.sv
verilog/egr_port_counters.sv
egr_width_conv/egr_width_conv.sv
egr_frame_fifo/egr_frame_fifo.sv
verilog/egr_port_array_adapt.sv
testbench/tb_egr_port_array_adapt.sv

//--- Bender.yml
package:
  name: egr_port_array_adapt

sources:
  # Shared package first, then the per-port blocks and the top level
  - files:
      - common/egr_pkg.sv
      - egr_port_gate/egr_port_gate.sv
      - verilog/egr_port_counters.sv
      - egr_width_conv/egr_width_conv.sv
      - egr_frame_fifo/egr_frame_fifo.sv
      - verilog/egr_port_array_adapt.sv

  - target: test
    files:
      - testbench/tb_egr_port_array_adapt.sv

//--- testbench/tb_egr_port_array_adapt.sv
// Testbench for the egress port array adapter
// Clock, reset, stimulus, reference model, comparison process and timeout
`timescale 1ns/100ps
`default_nettype none

module tb_egr_port_array_adapt;

    localparam int NP          = 2;
    localparam int IN_BYTES    = 8;
    localparam int OUT_BYTES   = 2;
    localparam int CNT_W       = 8;
    localparam int DEPTH       = 16;
    localparam int IN_W        = IN_BYTES * egr_pkg::BYTE_W;
    localparam int OUT_W       = OUT_BYTES * egr_pkg::BYTE_W;
    localparam int RATIO       = IN_BYTES / OUT_BYTES;
    localparam int WORD_W      = 1 + OUT_BYTES + OUT_W;
    localparam int MAX_BEATS   = 8;
    localparam int RAND_FRAMES = 12;
    localparam int SAT_FRAMES  = 260;

    logic                     clk;
    logic                     rst_n;
    logic [NP-1:0]            port_enable;
    logic [NP-1:0]            cnt_clear;
    logic [NP*IN_W-1:0]       s_tdata;
    logic [NP*IN_BYTES-1:0]   s_tkeep;
    logic [NP-1:0]            s_tlast;
    logic [NP-1:0]            s_tvalid;
    logic [NP-1:0]            s_tready;
    logic [NP*OUT_W-1:0]      m_tdata;
    logic [NP*OUT_BYTES-1:0]  m_tkeep;
    logic [NP-1:0]            m_tlast;
    logic [NP-1:0]            m_tvalid;
    logic [NP-1:0]            m_tready;
    logic [NP-1:0]            connected;
    logic [NP*CNT_W-1:0]      frame_cnt;
    logic [NP*CNT_W-1:0]      byte_cnt;
    logic [NP-1:0]            buf_drop;

    // Reference state
    logic [WORD_W-1:0] exp_q [NP][$];
    logic [IN_W-1:0]   frame_data [NP][MAX_BEATS];
    int                exp_cnt [NP][egr_pkg::NUM_CNTS];
    int                exp_drops [NP];
    int                drops_seen [NP];
    int                frames_done [NP];
    int                out_started [NP];
    bit                frame_start [NP];
    int                len_a [NP][RAND_FRAMES];
    int                last_a [NP][RAND_FRAMES];
    int                cycles = 0;
    int                cycle_limit = 0;

    egr_port_array_adapt #(
        .CNT_WIDTH  ( CNT_W ),
        .FIFO_DEPTH ( DEPTH )
    ) egr_port_array_adapt_i (
        .clk_i         ( clk         ),
        .rst_n_i       ( rst_n       ),
        .port_enable_i ( port_enable ),
        .cnt_clear_i   ( cnt_clear   ),
        .s_tdata_i     ( s_tdata     ),
        .s_tkeep_i     ( s_tkeep     ),
        .s_tlast_i     ( s_tlast     ),
        .s_tvalid_i    ( s_tvalid    ),
        .s_tready_o    ( s_tready    ),
        .m_tdata_o     ( m_tdata     ),
        .m_tkeep_o     ( m_tkeep     ),
        .m_tlast_o     ( m_tlast     ),
        .m_tvalid_o    ( m_tvalid    ),
        .m_tready_i    ( m_tready    ),
        .connected_o   ( connected   ),
        .frame_cnt_o   ( frame_cnt   ),
        .byte_cnt_o    ( byte_cnt    ),
        .buf_drop_o    ( buf_drop    )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reporting and reference model

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Counters stick at all ones
    function automatic logic [CNT_W-1:0] sat_count(input int n);
        return (n >= 2**CNT_W - 1) ? '1 : CNT_W'(n);
    endfunction

    // Queues the narrow beats of one frame, returns 1 if it reaches m_*
    function automatic bit expect_frame(input int p, input bit en, input int nbeats,
                                        input int last_bytes);
        int                  pieces;
        int                  last_pieces;
        int                  nwords;
        bit                  last;
        logic [IN_BYTES-1:0] keep;
        logic [IN_BYTES-1:0] last_keep;
        logic [IN_W-1:0]     data;
        if (!en) begin
            return 1'b0;
        end
        // Counters see every gated frame, even one the buffer later drops
        exp_cnt[p][egr_pkg::CNT_FRAMES] += 1;
        exp_cnt[p][egr_pkg::CNT_BYTES]  += (nbeats - 1) * IN_BYTES + last_bytes;
        // Last wide beat ends after its highest narrow piece with any keep bit
        last_keep   = IN_BYTES'((1 << last_bytes) - 1);
        last_pieces = 0;
        for (int k = 0; k < RATIO; k++) begin
            if (last_keep[k*OUT_BYTES +: OUT_BYTES] != '0) begin
                last_pieces = k + 1;
            end
        end
        nwords = (nbeats - 1) * RATIO + last_pieces;
        if (nwords > DEPTH) begin
            exp_drops[p] += 1;
            return 1'b0;
        end
        for (int b = 0; b < nbeats; b++) begin
            data   = frame_data[p][b];
            last   = (b == nbeats - 1);
            keep   = last ? last_keep : '1;
            pieces = last ? last_pieces : RATIO;
            for (int k = 0; k < pieces; k++) begin
                exp_q[p].push_back({last && (k == pieces - 1),
                                    keep[k*OUT_BYTES +: OUT_BYTES],
                                    data[k*OUT_W +: OUT_W]});
            end
        end
        return 1'b1;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    // Called 1 ns after a rising edge; flip toggles enable after the first beat
    task automatic send_frame(input int p, input int nbeats, input int last_bytes,
                              input bit en, input bit flip);
        bit appears;
        bit fired;
        for (int b = 0; b < nbeats; b++) begin
            frame_data[p][b] = {$urandom, $urandom};
        end
        appears = expect_frame(p, en, nbeats, last_bytes);
        port_enable[p] = en;
        for (int b = 0; b < nbeats; b++) begin
            s_tdata[p*IN_W +: IN_W]         = frame_data[p][b];
            s_tkeep[p*IN_BYTES +: IN_BYTES] = (b == nbeats - 1) ?
                IN_BYTES'((1 << last_bytes) - 1) : '1;
            s_tlast[p]  = (b == nbeats - 1);
            s_tvalid[p] = 1'b1;
            do begin
                @(negedge clk);
                fired = s_tready[p];
                @(posedge clk);
                #1;
            end while (!fired);
            if (flip && b == 0) begin
                port_enable[p] = !en;
            end
        end
        s_tvalid[p] = 1'b0;
        if (appears) begin
            frames_done[p] += 1;
        end
    endtask

    task automatic drive_ready(input int p);
        forever begin
            @(posedge clk);
            #1;
            m_tready[p] = ($urandom % 10) < 7;
        end
    endtask

    task automatic wait_idle();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            @(posedge clk);
        end
        // Counters and the drop pulse lag the stream by one cycle
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic check_counters();
        for (int p = 0; p < NP; p++) begin
            check_value($sformatf("frame_cnt_o[%0d]", p), frame_cnt[p*CNT_W +: CNT_W],
                        sat_count(exp_cnt[p][egr_pkg::CNT_FRAMES]));
            check_value($sformatf("byte_cnt_o[%0d]", p), byte_cnt[p*CNT_W +: CNT_W],
                        sat_count(exp_cnt[p][egr_pkg::CNT_BYTES]));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Comparison and timeout

    always @(negedge clk) begin
        logic [WORD_W-1:0] w;
        if (rst_n) begin
            for (int p = 0; p < NP; p++) begin
                if (buf_drop[p]) begin
                    drops_seen[p] += 1;
                end
                if (m_tvalid[p] && m_tready[p]) begin
                    if (exp_q[p].size() == 0) begin
                        report_failure($sformatf("port %0d sent a beat no frame accounts for", p));
                    end
                    w = exp_q[p].pop_front();
                    if (frame_start[p]) begin
                        check_value($sformatf("m_tvalid_o[%0d] start after input tlast", p),
                                    out_started[p] < frames_done[p], 1);
                        out_started[p] += 1;
                    end
                    check_value($sformatf("m_tdata_o[%0d]", p), m_tdata[p*OUT_W +: OUT_W],
                                w[OUT_W-1:0]);
                    check_value($sformatf("m_tkeep_o[%0d]", p),
                                m_tkeep[p*OUT_BYTES +: OUT_BYTES], w[WORD_W-2 -: OUT_BYTES]);
                    check_value($sformatf("m_tlast_o[%0d]", p), m_tlast[p], w[WORD_W-1]);
                    frame_start[p] = m_tlast[p];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles += 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            report_failure($sformatf("timeout, run still busy after %0d cycles", cycles));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int total;
        void'($urandom(32'h5aa6));
        rst_n       = 1'b0;
        port_enable = '0;
        cnt_clear   = '0;
        s_tdata     = '0;
        s_tkeep     = '0;
        s_tlast     = '0;
        s_tvalid    = '0;
        m_tready    = '0;
        total       = 0;
        for (int p = 0; p < NP; p++) begin
            exp_drops[p]   = 0;
            drops_seen[p]  = 0;
            frames_done[p] = 0;
            out_started[p] = 0;
            frame_start[p] = 1'b1;
            exp_cnt[p][egr_pkg::CNT_FRAMES] = 0;
            exp_cnt[p][egr_pkg::CNT_BYTES]  = 0;
            for (int f = 0; f < RAND_FRAMES; f++) begin
                len_a[p][f]  = 1 + $urandom % 4;
                last_a[p][f] = 1 + $urandom % 8;
                total += len_a[p][f];
            end
        end
        // Enable phase, saturation run and oversize phase
        total += 10 + SAT_FRAMES + 7;
        cycle_limit = 20 * total + 200;

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("m_tvalid_o", m_tvalid, 0);
        check_value("connected_o", connected, 0);
        check_value("buf_drop_o", buf_drop, 0);
        check_counters();

        fork
            drive_ready(0);
            drive_ready(1);
        join_none

        // Random frames on both ports at once
        fork
            begin
                for (int f = 0; f < RAND_FRAMES; f++) begin
                    send_frame(0, len_a[0][f], last_a[0][f], 1'b1, 1'b0);
                end
            end
            begin
                for (int f = 0; f < RAND_FRAMES; f++) begin
                    send_frame(1, len_a[1][f], last_a[1][f], 1'b1, 1'b0);
                end
            end
        join
        wait_idle();
        check_value("connected_o", connected, 2'b11);

        // Disabled port sinks frames, a mid-frame enable waits for the next frame
        send_frame(1, 3, 5, 1'b0, 1'b0);
        send_frame(1, 2, 8, 1'b0, 1'b0);
        wait_idle();
        check_value("connected_o[1]", connected[1], 0);
        send_frame(1, 3, 3, 1'b0, 1'b1);
        wait_idle();
        check_value("connected_o[1]", connected[1], 0);
        send_frame(1, 2, 6, 1'b1, 1'b0);
        wait_idle();
        check_value("connected_o[1]", connected[1], 1);
        check_counters();

        cnt_clear = '1;
        @(posedge clk);
        #1;
        cnt_clear = '0;
        for (int p = 0; p < NP; p++) begin
            exp_cnt[p][egr_pkg::CNT_FRAMES] = 0;
            exp_cnt[p][egr_pkg::CNT_BYTES]  = 0;
        end
        check_counters();

        // Short frames until both counts of port 0 saturate
        for (int f = 0; f < SAT_FRAMES; f++) begin
            send_frame(0, 1, 1 + $urandom % 8, 1'b1, 1'b0);
        end
        wait_idle();
        check_counters();

        // 20 narrow words cannot fit in 16, the next frame must pass intact
        send_frame(1, 5, 8, 1'b1, 1'b0);
        send_frame(1, 2, 4, 1'b1, 1'b0);
        wait_idle();
        check_value("buf_drop_o[0] pulses", drops_seen[0], exp_drops[0]);
        check_value("buf_drop_o[1] pulses", drops_seen[1], exp_drops[1]);
        check_counters();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/egr_port_array_adapt.sv
// Egress port array top level
// Per port chain of gate, counters, width converter and frame buffer
`timescale 1ns/100ps
`default_nettype none

module egr_port_array_adapt #(
    parameter int NUM_PORTS  = 2,
    parameter int IN_BYTES   = 8,
    parameter int OUT_BYTES  = 2,
    parameter int CNT_WIDTH  = 32,
    parameter int FIFO_DEPTH = 64
) (
    input  var logic                                            clk_i,
    input  var logic                                            rst_n_i,
    input  var logic [NUM_PORTS-1:0]                            port_enable_i,
    input  var logic [NUM_PORTS-1:0]                            cnt_clear_i,

    // Demuxed router bus, port p in slice p
    input  var logic [NUM_PORTS*IN_BYTES*egr_pkg::BYTE_W-1:0]   s_tdata_i,
    input  var logic [NUM_PORTS*IN_BYTES-1:0]                   s_tkeep_i,
    input  var logic [NUM_PORTS-1:0]                            s_tlast_i,
    input  var logic [NUM_PORTS-1:0]                            s_tvalid_i,
    output var logic [NUM_PORTS-1:0]                            s_tready_o,

    // Physical ports
    output var logic [NUM_PORTS*OUT_BYTES*egr_pkg::BYTE_W-1:0]  m_tdata_o,
    output var logic [NUM_PORTS*OUT_BYTES-1:0]                  m_tkeep_o,
    output var logic [NUM_PORTS-1:0]                            m_tlast_o,
    output var logic [NUM_PORTS-1:0]                            m_tvalid_o,
    input  var logic [NUM_PORTS-1:0]                            m_tready_i,

    output var logic [NUM_PORTS-1:0]                            connected_o,
    output var logic [NUM_PORTS*CNT_WIDTH-1:0]                  frame_cnt_o,
    output var logic [NUM_PORTS*CNT_WIDTH-1:0]                  byte_cnt_o,
    output var logic [NUM_PORTS-1:0]                            buf_drop_o
);

    localparam int IN_W  = IN_BYTES * egr_pkg::BYTE_W;
    localparam int OUT_W = OUT_BYTES * egr_pkg::BYTE_W;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : port_g

        // Gated wide stream
        logic [IN_W-1:0]     g_tdata;
        logic [IN_BYTES-1:0] g_tkeep;
        logic                g_tlast;
        logic                g_tvalid;
        logic                g_tready;

        // Narrow stream into the buffer
        logic [OUT_W-1:0]     n_tdata;
        logic [OUT_BYTES-1:0] n_tkeep;
        logic                 n_tlast;
        logic                 n_tvalid;
        logic                 n_tready;

        egr_port_gate #(
            .IN_BYTES ( IN_BYTES )
        ) gate_i (
            .clk_i       ( clk_i                               ),
            .rst_n_i     ( rst_n_i                             ),
            .enable_i    ( port_enable_i[p]                    ),
            .s_tdata_i   ( s_tdata_i[p*IN_W +: IN_W]           ),
            .s_tkeep_i   ( s_tkeep_i[p*IN_BYTES +: IN_BYTES]   ),
            .s_tlast_i   ( s_tlast_i[p]                        ),
            .s_tvalid_i  ( s_tvalid_i[p]                       ),
            .s_tready_o  ( s_tready_o[p]                       ),
            .g_tdata_o   ( g_tdata                             ),
            .g_tkeep_o   ( g_tkeep                             ),
            .g_tlast_o   ( g_tlast                             ),
            .g_tvalid_o  ( g_tvalid                            ),
            .g_tready_i  ( g_tready                            ),
            .connected_o ( connected_o[p]                      )
        );

        egr_port_counters #(
            .IN_BYTES  ( IN_BYTES  ),
            .CNT_WIDTH ( CNT_WIDTH )
        ) counters_i (
            .clk_i       ( clk_i                                 ),
            .rst_n_i     ( rst_n_i                               ),
            .clear_i     ( cnt_clear_i[p]                        ),
            .tkeep_i     ( g_tkeep                               ),
            .tlast_i     ( g_tlast                               ),
            .tvalid_i    ( g_tvalid                              ),
            .tready_i    ( g_tready                              ),
            .frame_cnt_o ( frame_cnt_o[p*CNT_WIDTH +: CNT_WIDTH] ),
            .byte_cnt_o  ( byte_cnt_o[p*CNT_WIDTH +: CNT_WIDTH]  )
        );

        egr_width_conv #(
            .IN_BYTES  ( IN_BYTES  ),
            .OUT_BYTES ( OUT_BYTES )
        ) width_conv_i (
            .clk_i      ( clk_i    ),
            .rst_n_i    ( rst_n_i  ),
            .s_tdata_i  ( g_tdata  ),
            .s_tkeep_i  ( g_tkeep  ),
            .s_tlast_i  ( g_tlast  ),
            .s_tvalid_i ( g_tvalid ),
            .s_tready_o ( g_tready ),
            .m_tdata_o  ( n_tdata  ),
            .m_tkeep_o  ( n_tkeep  ),
            .m_tlast_o  ( n_tlast  ),
            .m_tvalid_o ( n_tvalid ),
            .m_tready_i ( n_tready )
        );

        egr_frame_fifo #(
            .OUT_BYTES  ( OUT_BYTES  ),
            .FIFO_DEPTH ( FIFO_DEPTH )
        ) frame_fifo_i (
            .clk_i      ( clk_i                                ),
            .rst_n_i    ( rst_n_i                              ),
            .s_tdata_i  ( n_tdata                              ),
            .s_tkeep_i  ( n_tkeep                              ),
            .s_tlast_i  ( n_tlast                              ),
            .s_tvalid_i ( n_tvalid                             ),
            .s_tready_o ( n_tready                             ),
            .m_tdata_o  ( m_tdata_o[p*OUT_W +: OUT_W]          ),
            .m_tkeep_o  ( m_tkeep_o[p*OUT_BYTES +: OUT_BYTES]  ),
            .m_tlast_o  ( m_tlast_o[p]                         ),
            .m_tvalid_o ( m_tvalid_o[p]                        ),
            .m_tready_i ( m_tready_i[p]                        ),
            .buf_drop_o ( buf_drop_o[p]                        )
        );

    end

endmodule

`default_nettype wire

//--- egr_frame_fifo/egr_frame_fifo.sv
// Store-and-forward frame buffer with oversize frame drop
`timescale 1ns/100ps
`default_nettype none

module egr_frame_fifo #(
    parameter int OUT_BYTES  = 2,
    parameter int FIFO_DEPTH = 64
) (
    input  var logic                                  clk_i,
    input  var logic                                  rst_n_i,

    input  var logic [OUT_BYTES*egr_pkg::BYTE_W-1:0]  s_tdata_i,
    input  var logic [OUT_BYTES-1:0]                  s_tkeep_i,
    input  var logic                                  s_tlast_i,
    input  var logic                                  s_tvalid_i,
    output var logic                                  s_tready_o,

    output var logic [OUT_BYTES*egr_pkg::BYTE_W-1:0]  m_tdata_o,
    output var logic [OUT_BYTES-1:0]                  m_tkeep_o,
    output var logic                                  m_tlast_o,
    output var logic                                  m_tvalid_o,
    input  var logic                                  m_tready_i,

    output var logic                                  buf_drop_o
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int WW = OUT_BYTES * egr_pkg::BYTE_W + OUT_BYTES + 1;

    if (FIFO_DEPTH < 2 || (1 << AW) != FIFO_DEPTH) begin : depth_chk_g
        $error("FIFO_DEPTH must be a power of two, at least 2");
    end

    // Word layout is {last, keep, data}
    logic [WW-1:0] mem [FIFO_DEPTH];

    // Pointers carry one extra wrap bit
    logic [AW:0] wr_q;
    logic [AW:0] cm_q;
    logic [AW:0] rd_q;
    logic [AW:0] occ;
    logic [AW:0] frame_len;

    logic drop_q;
    logic drop_pulse_q;
    logic full;
    logic frame_full;
    logic s_beat;
    logic cut;

    assign occ        = wr_q - rd_q;
    assign frame_len  = wr_q - cm_q;
    assign full       = occ == (AW+1)'(FIFO_DEPTH);
    assign frame_full = frame_len == (AW+1)'(FIFO_DEPTH);

    // Full with older frames back-pressures, full with one frame means it can never fit
    assign s_tready_o = drop_q | frame_full | !full;
    assign s_beat     = s_tvalid_i & s_tready_o;
    assign cut        = s_beat & (drop_q | frame_full);

    ////////////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk_i) begin
        if (s_beat && !cut) begin
            mem[wr_q[AW-1:0]] <= {s_tlast_i, s_tkeep_i, s_tdata_i};
        end
    end

    // Only committed words are visible
    assign m_tvalid_o = rd_q != cm_q;
    assign {m_tlast_o, m_tkeep_o, m_tdata_o} = mem[rd_q[AW-1:0]];
    assign buf_drop_o = drop_pulse_q;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and drop state

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_q         <= '0;
            cm_q         <= '0;
            rd_q         <= '0;
            drop_q       <= 1'b0;
            drop_pulse_q <= 1'b0;
        end else begin
            drop_pulse_q <= cut & s_tlast_i;
            if (cut) begin
                // Roll the partial frame back and sink the rest of it
                wr_q   <= cm_q;
                drop_q <= !s_tlast_i;
            end else if (s_beat) begin
                wr_q <= wr_q + 1'b1;
                if (s_tlast_i) begin
                    cm_q <= wr_q + 1'b1;
                end
            end
            if (m_tvalid_o && m_tready_i) begin
                rd_q <= rd_q + 1'b1;
            end
        end
    end

    a_occ_bound : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        occ <= (AW+1)'(FIFO_DEPTH)
    ) else $error("frame buffer occupancy above depth");

endmodule

`default_nettype wire

//--- egr_width_conv/egr_width_conv.sv
// Downsizing stream width converter, router bus to port width
`timescale 1ns/100ps
`default_nettype none

module egr_width_conv #(
    parameter int IN_BYTES  = 8,
    parameter int OUT_BYTES = 2
) (
    input  var logic                                  clk_i,
    input  var logic                                  rst_n_i,

    input  var logic [IN_BYTES*egr_pkg::BYTE_W-1:0]   s_tdata_i,
    input  var logic [IN_BYTES-1:0]                   s_tkeep_i,
    input  var logic                                  s_tlast_i,
    input  var logic                                  s_tvalid_i,
    output var logic                                  s_tready_o,

    output var logic [OUT_BYTES*egr_pkg::BYTE_W-1:0]  m_tdata_o,
    output var logic [OUT_BYTES-1:0]                  m_tkeep_o,
    output var logic                                  m_tlast_o,
    output var logic                                  m_tvalid_o,
    input  var logic                                  m_tready_i
);

    localparam int RATIO = IN_BYTES / OUT_BYTES;
    localparam int IDX_W = (RATIO > 1) ? $clog2(RATIO) : 1;
    localparam int OUT_W = OUT_BYTES * egr_pkg::BYTE_W;

    if (IN_BYTES % OUT_BYTES != 0) begin : ratio_chk_g
        $error("OUT_BYTES must divide IN_BYTES");
    end

    // Held wide beat
    logic [IN_BYTES*egr_pkg::BYTE_W-1:0] data_q;
    logic [IN_BYTES-1:0]                 keep_q;
    logic                                last_q;

    logic             valid_q;
    logic [IDX_W-1:0] idx_q;
    logic [IDX_W-1:0] last_idx_q;
    logic [IDX_W-1:0] last_idx_d;
    int unsigned      pieces;
    logic             piece_done;

    // Pieces on a trimmed last beat, rounded up to whole narrow words
    assign pieces = (egr_pkg::keep_count(egr_pkg::MAX_KEEP_W'(s_tkeep_i)) + OUT_BYTES - 1)
                    / OUT_BYTES;
    assign last_idx_d = s_tlast_i ? IDX_W'(pieces - 1) : IDX_W'(RATIO - 1);

    assign piece_done = m_tvalid_o & m_tready_i & (idx_q == last_idx_q);
    assign s_tready_o = !valid_q | piece_done;

    ////////////////////////////////////////////////////////////////////////////
    // Output slice, low piece first

    assign m_tvalid_o = valid_q;
    assign m_tdata_o  = data_q[idx_q*OUT_W +: OUT_W];
    assign m_tkeep_o  = keep_q[idx_q*OUT_BYTES +: OUT_BYTES];
    assign m_tlast_o  = last_q & (idx_q == last_idx_q);

    always_ff @(posedge clk_i) begin
        if (s_tvalid_i && s_tready_o) begin
            data_q <= s_tdata_i;
            keep_q <= s_tkeep_i;
            last_q <= s_tlast_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q    <= 1'b0;
            idx_q      <= '0;
            last_idx_q <= '0;
        end else if (s_tvalid_i && s_tready_o) begin
            valid_q    <= 1'b1;
            idx_q      <= '0;
            last_idx_q <= last_idx_d;
        end else if (piece_done) begin
            valid_q <= 1'b0;
        end else if (m_tvalid_o && m_tready_i) begin
            idx_q <= idx_q + 1'b1;
        end
    end

    // Stalled narrow beat must not change under the sink
    a_hold_stalled : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        m_tvalid_o && !m_tready_i |=> $stable(m_tdata_o)
    ) else $error("m_tdata changed while stalled");

endmodule

`default_nettype wire

//--- verilog/egr_port_counters.sv
// Saturating frame and byte counters on the gated stream of one port
`timescale 1ns/100ps
`default_nettype none

module egr_port_counters #(
    parameter int IN_BYTES  = 8,
    parameter int CNT_WIDTH = 32
) (
    input  var logic                  clk_i,
    input  var logic                  rst_n_i,
    input  var logic                  clear_i,

    // Passive tap on the gated stream
    input  var logic [IN_BYTES-1:0]   tkeep_i,
    input  var logic                  tlast_i,
    input  var logic                  tvalid_i,
    input  var logic                  tready_i,

    output var logic [CNT_WIDTH-1:0]  frame_cnt_o,
    output var logic [CNT_WIDTH-1:0]  byte_cnt_o
);

    logic                 beat;
    logic [CNT_WIDTH-1:0] inc   [egr_pkg::NUM_CNTS];
    logic [CNT_WIDTH:0]   sum   [egr_pkg::NUM_CNTS];
    logic [CNT_WIDTH-1:0] cnt_d [egr_pkg::NUM_CNTS];
    logic [CNT_WIDTH-1:0] cnt_q [egr_pkg::NUM_CNTS];

    assign beat = tvalid_i & tready_i;

    ////////////////////////////////////////////////////////////////////////////
    // Increments and saturating adders

    always_comb begin
        inc[egr_pkg::CNT_FRAMES] = (beat && tlast_i) ? CNT_WIDTH'(1) : '0;
        inc[egr_pkg::CNT_BYTES]  = beat ?
            CNT_WIDTH'(egr_pkg::keep_count(egr_pkg::MAX_KEEP_W'(tkeep_i))) : '0;

        for (int c = 0; c < egr_pkg::NUM_CNTS; c++) begin
            sum[c] = {1'b0, cnt_q[c]} + {1'b0, inc[c]};
            // Carry out means the count sticks at all ones
            cnt_d[c] = sum[c][CNT_WIDTH] ? '1 : sum[c][CNT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int c = 0; c < egr_pkg::NUM_CNTS; c++) begin
                cnt_q[c] <= '0;
            end
        end else begin
            for (int c = 0; c < egr_pkg::NUM_CNTS; c++) begin
                // Clear wins over a same-cycle increment
                cnt_q[c] <= clear_i ? '0 : cnt_d[c];
            end
        end
    end

    assign frame_cnt_o = cnt_q[egr_pkg::CNT_FRAMES];
    assign byte_cnt_o  = cnt_q[egr_pkg::CNT_BYTES];

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    for (genvar c = 0; c < egr_pkg::NUM_CNTS; c++) begin : cnt_chk_g
        a_no_wrap : assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            !clear_i |=> cnt_q[c] >= $past(cnt_q[c])
        ) else $error("counter %0d went backwards without a clear", c);
    end

endmodule

`default_nettype wire

//--- egr_port_gate/egr_port_gate.sv
// Frame-aware enable gate for one egress port
`timescale 1ns/100ps
`default_nettype none

module egr_port_gate #(
    parameter int IN_BYTES = 8
) (
    input  var logic                                 clk_i,
    input  var logic                                 rst_n_i,
    input  var logic                                 enable_i,

    input  var logic [IN_BYTES*egr_pkg::BYTE_W-1:0]  s_tdata_i,
    input  var logic [IN_BYTES-1:0]                  s_tkeep_i,
    input  var logic                                 s_tlast_i,
    input  var logic                                 s_tvalid_i,
    output var logic                                 s_tready_o,

    output var logic [IN_BYTES*egr_pkg::BYTE_W-1:0]  g_tdata_o,
    output var logic [IN_BYTES-1:0]                  g_tkeep_o,
    output var logic                                 g_tlast_o,
    output var logic                                 g_tvalid_o,
    input  var logic                                 g_tready_i,

    output var logic                                 connected_o
);

    logic mid_q;
    logic en_q;
    logic pass;
    logic s_beat;

    // A frame start samples enable_i, the rest of the frame keeps the latched state
    assign pass   = mid_q ? en_q : enable_i;
    assign s_beat = s_tvalid_i & s_tready_o;

    // Closed gate sinks every beat
    assign s_tready_o = pass ? g_tready_i : 1'b1;
    assign g_tvalid_o = s_tvalid_i & pass;
    assign g_tdata_o  = s_tdata_i;
    assign g_tkeep_o  = s_tkeep_i;
    assign g_tlast_o  = s_tlast_i;

    assign connected_o = en_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mid_q <= 1'b0;
            en_q  <= 1'b0;
        end else if (s_beat) begin
            mid_q <= !s_tlast_i;
            if (!mid_q) begin
                en_q <= enable_i;
            end
        end
    end

    // No frame is ever cut by an enable change
    a_enable_stable_mid_frame : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mid_q |-> $stable(pass)
    ) else $error("enable state changed inside a frame");

endmodule

`default_nettype wire

//--- common/egr_pkg.sv
// Shared widths, counter indices and keep helpers for the egress port adapter
`default_nettype none

package egr_pkg;

    // Bits per data byte
    localparam int BYTE_W = 8;

    // Widest keep mask the helpers accept
    localparam int MAX_KEEP_W = 64;

    ////////////////////////////////////////////////////////////////////////////
    // Counter layout per port

    localparam int NUM_CNTS   = 2;
    localparam int CNT_FRAMES = 0;
    localparam int CNT_BYTES  = 1;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    // Valid bytes in a keep mask, contiguous from the low byte
    function automatic int unsigned keep_count(input logic [MAX_KEEP_W-1:0] keep);
        int unsigned n;
        n = 0;
        for (int i = 0; i < MAX_KEEP_W; i++) begin
            n += int'(keep[i]);
        end
        return n;
    endfunction

endpackage

`default_nettype wire
